// ==== Makefile ====
# Verilator build and run of the accumulator testbench
VERILATOR ?= verilator
TOP       ?= tb_mop_accum
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= mop_accum.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	! grep -q "=== FAIL ===" $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== mop_accum.f ====
+incdir+rtl
rtl/lau_pkg.sv
rtl/accum_if.sv
rtl/add_mop_csv.sv
rtl/add_cpa.sv
rtl/csa_accum.sv
rtl/group_counter.sv
rtl/accum_ctrl.sv
rtl/mop_accum.sv
sim/tb_mop_accum.sv

// ==== rtl/accum_ctrl.sv ====
// sequencer for clear, accumulate and resolve
module accum_ctrl (
	input  logic     clk,
	input  logic     reset,
	input  logic     start,
	input  logic     operand_valid,
	input  logic     last_group,
	output logic     busy,
	output logic     done,
	accum_if.ctrl    ctrl
);

	lau_pkg::ctrl_state_e state;
	lau_pkg::ctrl_state_e state_next;

	// start only counts when idle
	assign ctrl.clear      = (state == lau_pkg::IDLE) && start;
	assign ctrl.count_load = (state == lau_pkg::IDLE) && start;
	// strobes outside ACCUM are dropped
	assign ctrl.accumulate = (state == lau_pkg::ACCUM) && operand_valid;
	// one cycle to register the CPA output
	assign ctrl.resolve    = (state == lau_pkg::RESOLVE);

	always_comb begin
		state_next = state;
		case (state)
			lau_pkg::IDLE: begin
				if (start) begin
					state_next = lau_pkg::ACCUM;
				end
			end
			lau_pkg::ACCUM: begin
				// leave once the final group is in
				if (operand_valid && last_group) begin
					state_next = lau_pkg::RESOLVE;
				end
			end
			lau_pkg::RESOLVE: begin
				state_next = lau_pkg::IDLE;
			end
			default: begin
				state_next = lau_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= lau_pkg::IDLE;
		end else begin
			state <= state_next;
		end
	end

	// done follows the resolve edge by one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= ctrl.resolve;
		end
	end

	// busy drops together with done
	assign busy = (state != lau_pkg::IDLE);

endmodule

// ==== rtl/accum_if.sv ====
// control strobes from sequencer to datapath
interface accum_if;

	// zero the redundant sum and carry
	logic clear;
	// fold the present operand group in
	logic accumulate;
	// capture the resolved binary sum
	logic resolve;
	// load the outstanding group count
	logic count_load;

	// sequencer side
	modport ctrl (
		output clear,
		output accumulate,
		output resolve,
		output count_load
	);

	// register and counter side
	modport datapath (
		input clear,
		input accumulate,
		input resolve,
		input count_load
	);

endinterface

// ==== rtl/add_cpa.sv ====
// carry-propagate adder, carry out dropped
module add_cpa #(
	parameter int              width = 8,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	output logic [width-1:0] s
);

	if (speed == lau_pkg::SLOW) begin : g_ripple
		// plain carry ripple, lsb first
		always_comb begin : ripple
			logic carry;
			carry = 1'b0;
			for (int i = 0; i < width; i++) begin
				s[i]  = a[i] ^ b[i] ^ carry;
				carry = (a[i] & b[i]) | (carry & (a[i] ^ b[i]));
			end
		end
	end else begin : g_sklansky
		// enough levels to span the whole word
		localparam int levels = lau_pkg::log2floor(width - 1) + 1;

		// group generate and propagate per level
		logic [levels:0][width-1:0] gen;
		logic [levels:0][width-1:0] prop;

		assign gen[0]  = a & b;
		assign prop[0] = a ^ b;

		for (genvar l = 0; l < levels; l++) begin : g_level
			for (genvar i = 0; i < width; i++) begin : g_bit
				if (((i >> l) % 2) == 1) begin : g_merge
					// top bit of the lower half block
					localparam int j = ((i >> l) << l) - 1;
					assign gen[l+1][i]  = gen[l][i] | (prop[l][i] & gen[l][j]);
					assign prop[l+1][i] = prop[l][i] & prop[l][j];
				end else begin : g_pass
					assign gen[l+1][i]  = gen[l][i];
					assign prop[l+1][i] = prop[l][i];
				end
			end
		end

		// carry into bit i is the prefix up to i-1
		assign s = prop[0] ^ {gen[levels][width-2:0], 1'b0};
	end

endmodule

// ==== rtl/add_mop_csv.sv ====
// carry-save adder over depth operands
// only S + C is meaningful
// the split depends on the tree shape
module add_mop_csv #(
	parameter int              width = 8,
	parameter int              depth = 4,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic [depth*width-1:0] A,
	output logic [      width-1:0] S,
	output logic [      width-1:0] C
);

	// operand bits regrouped by weight
	logic [      depth*width-1:0] bits_by_weight;
	// carries passed between neighbouring slices
	logic [(depth-3)*(width+1)-1:0] ci_chain;
	// slice carries before the weight shift
	logic [            width-1:0] c_slice;

	// bit i of every operand lands in one group
	always_comb begin : regroup
		for (int i = 0; i < width; i++) begin
			for (int k = 0; k < depth; k++) begin
				bits_by_weight[i*depth+k] = A[k*width+i];
			end
		end
	end

	// lowest slice sees no incoming carries
	assign ci_chain[depth-4:0] = '0;

	// one compressor per bit position
	for (genvar i = 0; i < width; i++) begin : g_bits
		cpr #(
			.depth(depth),
			.speed(speed)
		) i_slice (
			.A (bits_by_weight[i*depth +: depth]),
			.CI(ci_chain[i*(depth-3) +: depth-3]),
			.S (S[i]),
			.C (c_slice[i]),
			.CO(ci_chain[(i+1)*(depth-3) +: depth-3])
		);
	end

	// carries weigh one position more
	// top slice carries fall off so the sum wraps
	assign C = {c_slice[width-2:0], 1'b0};

endmodule

// (depth,2) compressor for one bit position
module cpr #(
	parameter int              depth = 4,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic [depth-1:0] A,
	input  logic [depth-4:0] CI,
	output logic             S,
	output logic             C,
	output logic [depth-4:0] CO
);

	// work queue of inputs then sum and carry-in pairs
	logic [3*depth-6:0] q;
	// carries out of each full adder
	logic [  depth-3:0] cout_fa;

	assign q[depth-1:0] = A;

	// carry-in k sits right after sum k
	for (genvar i = 0; i < depth-3; i++) begin : g_queue
		assign q[depth+2*i+1] = CI[i];
	end

	if (speed == lau_pkg::SLOW) begin : g_linear
		// first three inputs start the chain
		full_adder i_fa0 (
			.a (q[0]),
			.b (q[1]),
			.ci(q[2]),
			.s (q[depth]),
			.co(cout_fa[0])
		);
		// each stage adds one input and one carry-in
		for (genvar i = 1; i < depth-2; i++) begin : g_stage
			full_adder i_fa (
				.a (q[i+2]),
				.b (q[depth+2*i-1]),
				.ci(q[depth+2*i-2]),
				.s (q[depth+2*i]),
				.co(cout_fa[i])
			);
		end
	end else begin : g_tree
		// consume three queue entries and append the sum
		for (genvar i = 0; i < depth-2; i++) begin : g_stage
			full_adder i_fa (
				.a (q[3*i]),
				.b (q[3*i+1]),
				.ci(q[3*i+2]),
				.s (q[depth+2*i]),
				.co(cout_fa[i])
			);
		end
	end

	// all but the last carry go to the next slice
	assign CO = cout_fa[depth-4:0];
	// final adder gives slice sum and carry
	assign S  = q[3*depth-6];
	assign C  = cout_fa[depth-3];

endmodule

// single-bit full adder
module full_adder (
	input  logic a,
	input  logic b,
	input  logic ci,
	output logic s,
	output logic co
);

	// half sum shared by both outputs
	logic half;

	assign half = a ^ b;
	assign s    = half ^ ci;
	assign co   = (a & b) | (half & ci);

endmodule

// ==== rtl/csa_accum.sv ====
`include "mop_config.svh"

// redundant accumulator with final resolve
module csa_accum (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [`MOP_LANES*`MOP_WIDTH-1:0]    operands,
	accum_if.datapath                           dp,
	output logic [`MOP_ACC_WIDTH-1:0]           sum
);

	// new lanes plus stored sum and carry
	localparam int depth = `MOP_LANES + 2;

	// compressor inputs, one accumulator word each
	logic [depth*`MOP_ACC_WIDTH-1:0] tree_in;
	// stored redundant pair
	logic [`MOP_ACC_WIDTH-1:0]       sum_q;
	logic [`MOP_ACC_WIDTH-1:0]       carry_q;
	// pair after folding the present group
	logic [`MOP_ACC_WIDTH-1:0]       sum_next;
	logic [`MOP_ACC_WIDTH-1:0]       carry_next;
	// binary value of the stored pair
	logic [`MOP_ACC_WIDTH-1:0]       resolved;

	// zero-extend lanes, append feedback words
	always_comb begin : pack_tree
		for (int k = 0; k < `MOP_LANES; k++) begin
			tree_in[k*`MOP_ACC_WIDTH +: `MOP_ACC_WIDTH] = {
				{(`MOP_ACC_WIDTH-`MOP_WIDTH){1'b0}},
				operands[k*`MOP_WIDTH +: `MOP_WIDTH]
			};
		end
		tree_in[`MOP_LANES*`MOP_ACC_WIDTH +: `MOP_ACC_WIDTH]     = sum_q;
		tree_in[(`MOP_LANES+1)*`MOP_ACC_WIDTH +: `MOP_ACC_WIDTH] = carry_q;
	end

	add_mop_csv #(
		.width(`MOP_ACC_WIDTH),
		.depth(depth),
		.speed(`MOP_SPEED)
	) i_csv (
		.A(tree_in),
		.S(sum_next),
		.C(carry_next)
	);

	// pair captured only while a group is strobed
	always_ff @(posedge clk) begin
		if (dp.clear) begin
			sum_q   <= '0;
			carry_q <= '0;
		end else if (dp.accumulate) begin
			sum_q   <= sum_next;
			carry_q <= carry_next;
		end
	end

	add_cpa #(
		.width(`MOP_ACC_WIDTH),
		.speed(`MOP_SPEED)
	) i_cpa (
		.a(sum_q),
		.b(carry_q),
		.s(resolved)
	);

	// result holds until the next resolve
	always_ff @(posedge clk) begin
		if (reset) begin
			sum <= '0;
		end else if (dp.resolve) begin
			sum <= resolved;
		end
	end

endmodule

// ==== rtl/group_counter.sv ====
`include "mop_config.svh"

// groups still expected in this run
module group_counter (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`MOP_COUNT_WIDTH-1:0] group_count,
	accum_if.datapath                   dp,
	output logic                        last_group
);

	// outstanding groups
	logic [`MOP_COUNT_WIDTH-1:0] remaining;

	always_ff @(posedge clk) begin
		if (reset) begin
			remaining <= '0;
		end else if (dp.count_load) begin
			// zero requested means one group
			if (group_count == '0) begin
				remaining <= `MOP_COUNT_WIDTH'(1);
			end else begin
				remaining <= group_count;
			end
		end else if (dp.accumulate) begin
			remaining <= remaining - 1'b1;
		end
	end

	// next accepted group closes the run
	assign last_group = (remaining == `MOP_COUNT_WIDTH'(1));

endmodule

// ==== rtl/lau_pkg.sv ====
package lau_pkg;

	// floor of log2, yields -1 for n below one
	function automatic int log2floor(input int n);
		int level;
		int power;
		level = -1;
		power = 1;
		// double until past n
		while (power <= n) begin
			level = level + 1;
			power = power * 2;
		end
		return level;
	endfunction

	// structure choice for arithmetic blocks
	typedef enum logic [1:0] {
		SLOW   = 2'b00,
		MEDIUM = 2'b01,
		FAST   = 2'b10
	} speed_e;

	// accumulator sequencer states
	typedef enum logic [1:0] {
		IDLE    = 2'b00,
		ACCUM   = 2'b01,
		RESOLVE = 2'b10
	} ctrl_state_e;

endpackage

// ==== rtl/mop_accum.sv ====
`include "mop_config.svh"

// multi-operand accumulator top level
module mop_accum (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                start,
	input  logic [`MOP_COUNT_WIDTH-1:0]         group_count,
	input  logic                                operand_valid,
	input  logic [`MOP_LANES*`MOP_WIDTH-1:0]    operands,
	output logic                                busy,
	output logic                                done,
	output logic [`MOP_ACC_WIDTH-1:0]           sum
);

	// sequencer strobes to counter and datapath
	accum_if ctl_bus ();

	// counter reports the final group
	logic last_group;

	accum_ctrl i_ctrl (
		.clk          (clk),
		.reset        (reset),
		.start        (start),
		.operand_valid(operand_valid),
		.last_group   (last_group),
		.busy         (busy),
		.done         (done),
		.ctrl         (ctl_bus.ctrl)
	);

	group_counter i_counter (
		.clk        (clk),
		.reset      (reset),
		.group_count(group_count),
		.dp         (ctl_bus.datapath),
		.last_group (last_group)
	);

	csa_accum i_datapath (
		.clk     (clk),
		.reset   (reset),
		.operands(operands),
		.dp      (ctl_bus.datapath),
		.sum     (sum)
	);

endmodule

// ==== rtl/mop_config.svh ====
`ifndef MOP_CONFIG_SVH
`define MOP_CONFIG_SVH

// width of one unsigned operand
`define MOP_WIDTH 16

// accumulator and result width, sum wraps at this size
`define MOP_ACC_WIDTH 24

// operands delivered per strobe
`define MOP_LANES 4

// width of the group count sampled with start
`define MOP_COUNT_WIDTH 8

// structure of compressor tree and final adder
`define MOP_SPEED lau_pkg::FAST

`endif

// ==== sim/tb_mop_accum.sv ====
`include "mop_config.svh"

module tb_mop_accum;

	// strobes and gaps of all tests plus start and resolve cycles per run
	localparam int max_groups  = 3 + 1 + 20 * 40 + 255 + 24 + 2;
	localparam int max_gaps    = 24 * 3;
	localparam int max_runs    = 1 + 20 + 1 + 2;
	localparam int cycle_limit = 16 + max_groups + max_gaps + max_runs * 6 + 100;

	logic                             clk;
	logic                             reset;
	logic                             start;
	logic [`MOP_COUNT_WIDTH-1:0]      group_count;
	logic                             operand_valid;
	logic [`MOP_LANES*`MOP_WIDTH-1:0] operands;
	logic                             busy;
	logic                             done;
	logic [`MOP_ACC_WIDTH-1:0]        sum;

	// reference model state
	lau_pkg::ctrl_state_e      m_phase;
	int                        m_left;
	logic [`MOP_ACC_WIDTH-1:0] m_acc;
	logic [`MOP_ACC_WIDTH-1:0] m_result;
	logic                      m_done;
	logic                      m_last;
	logic                      m_busy;
	logic [`MOP_ACC_WIDTH-1:0] run_log[$];

	int seed = 47701;
	int errors = 0;
	int tests = 0;
	int failed = 0;
	int errors_at_start = 0;
	int done_count = 0;
	int cycles = 0;

	mop_accum i_mop_accum (
		.clk          (clk),
		.reset        (reset),
		.start        (start),
		.group_count  (group_count),
		.operand_valid(operand_valid),
		.operands     (operands),
		.busy         (busy),
		.done         (done),
		.sum          (sum)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// unsigned lanes summed with wrap at the accumulator width
	function automatic logic [`MOP_ACC_WIDTH-1:0] lane_sum(
		input logic [`MOP_LANES*`MOP_WIDTH-1:0] ops
	);
		logic [`MOP_ACC_WIDTH-1:0] total;
		total = '0;
		for (int k = 0; k < `MOP_LANES; k++) begin
			total = total + `MOP_ACC_WIDTH'(ops[k*`MOP_WIDTH +: `MOP_WIDTH]);
		end
		return total;
	endfunction

	// model of the run sequence, edge for edge
	always @(posedge clk) begin
		if (reset) begin
			m_phase  <= lau_pkg::IDLE;
			m_left   <= 0;
			m_acc    <= '0;
			m_result <= '0;
			m_done   <= 1'b0;
			m_last   <= 1'b0;
		end else begin
			m_done <= (m_phase == lau_pkg::RESOLVE);
			m_last <= 1'b0;
			case (m_phase)
				lau_pkg::IDLE: begin
					if (start) begin
						m_phase <= lau_pkg::ACCUM;
						m_left  <= (group_count == '0) ? 1 : int'(group_count);
						m_acc   <= '0;
					end
				end
				lau_pkg::ACCUM: begin
					if (operand_valid) begin
						m_acc  <= m_acc + lane_sum(operands);
						m_left <= m_left - 1;
						// final group taken at this edge
						if (m_left == 1) begin
							m_phase <= lau_pkg::RESOLVE;
							m_last  <= 1'b1;
						end
					end
				end
				default: begin
					m_phase  <= lau_pkg::IDLE;
					m_result <= m_acc;
					run_log.push_back(m_acc);
				end
			endcase
		end
	end

	assign m_busy = (m_phase != lau_pkg::IDLE);

	always @(negedge clk) begin
		if (done) begin
			done_count++;
		end
	end

	a_busy: assert property (@(posedge clk) disable iff (reset) busy == m_busy)
		else begin
			errors++;
			$display("[ERROR] %0t busy expected %b actual %b", $time, $sampled(m_busy),
				$sampled(busy));
		end

	// also catches a done without a finished run
	a_done: assert property (@(posedge clk) disable iff (reset) done == m_done)
		else begin
			errors++;
			$display("[ERROR] %0t done expected %b actual %b", $time, $sampled(m_done),
				$sampled(done));
		end

	a_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else begin
			errors++;
			$display("done stayed high for more than one cycle at %0t", $time);
		end

	// last strobe at edge k and done seen at edge k+2
	a_latency: assert property (@(posedge clk) disable iff (reset) m_last |=> done)
		else begin
			errors++;
			$display("done did not follow the last strobe by two edges at %0t", $time);
		end

	a_sum: assert property (@(posedge clk) disable iff (reset) done |-> sum == m_result)
		else begin
			errors++;
			$display("[ERROR] %0t sum expected %h actual %h", $time, $sampled(m_result),
				$sampled(sum));
		end

	task automatic start_run(input int count);
		start       = 1'b1;
		group_count = `MOP_COUNT_WIDTH'(count);
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic send_group(input logic [`MOP_LANES*`MOP_WIDTH-1:0] ops, input int gap);
		operand_valid = 1'b1;
		operands      = ops;
		@(negedge clk);
		operand_valid = 1'b0;
		repeat (gap) @(negedge clk);
	endtask

	// poll done on falling edges
	task automatic wait_done();
		while (!done) begin
			@(negedge clk);
		end
		// one edge more so the pulse is counted
		@(negedge clk);
	endtask

	function automatic logic [`MOP_LANES*`MOP_WIDTH-1:0] random_ops();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic check_value(
		input string                     name,
		input logic [`MOP_ACC_WIDTH-1:0] expected,
		input logic [`MOP_ACC_WIDTH-1:0] actual
	);
		a_value: assert (actual === expected)
			else begin
				errors++;
				$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected,
					actual);
			end
	endtask

	task automatic finish_test(input string name);
		a_done_count: assert (done_count == run_log.size())
			else begin
				errors++;
				$display("[ERROR] %0t done pulses expected %0d actual %0d", $time,
					run_log.size(), done_count);
			end
		tests++;
		if (errors != errors_at_start) begin
			failed++;
		end
		$display("test %0d %s: %s", tests, name, (errors != errors_at_start) ? "failed" : "ok");
		errors_at_start = errors;
	endtask

	initial begin
		logic [`MOP_LANES*`MOP_WIDTH-1:0] first_ops;
		int count;
		reset         = 1'b1;
		start         = 1'b0;
		group_count   = '0;
		operand_valid = 1'b0;
		operands      = '0;
		repeat (16) @(negedge clk);
		reset = 1'b0;

		// reset values then strobes while idle
		check_value("busy", 1'b0, busy);
		check_value("done", 1'b0, done);
		check_value("sum", '0, sum);
		check_value("state", lau_pkg::IDLE, i_mop_accum.i_ctrl.state);
		operand_valid = 1'b1;
		operands      = random_ops();
		repeat (3) @(negedge clk);
		operand_valid = 1'b0;
		repeat (4) @(negedge clk);
		finish_test("reset and idle strobes");

		start_run(1);
		send_group({16'd4000, 16'd3000, 16'd2000, 16'd1000}, 0);
		wait_done();
		check_value("sum", `MOP_ACC_WIDTH'(10000), sum);
		finish_test("single fixed group");

		for (int r = 0; r < 20; r++) begin
			count = 1 + ($unsigned($random(seed)) % 40);
			start_run(count);
			for (int i = 0; i < count; i++) begin
				send_group(random_ops(), 0);
			end
			wait_done();
		end
		finish_test("random runs");

		start_run(255);
		repeat (255) send_group('1, 0);
		wait_done();
		check_value("sum", `MOP_ACC_WIDTH'(255 * `MOP_LANES * 65535), sum);
		finish_test("all ones wrap");

		// gaps between strobes and a start while busy
		start_run(24);
		for (int i = 0; i < 24; i++) begin
			if (i == 6) begin
				start       = 1'b1;
				group_count = `MOP_COUNT_WIDTH'(3);
			end
			send_group(random_ops(), (i == 23) ? 0 : ($unsigned($random(seed)) % 4));
			start = 1'b0;
		end
		wait_done();
		// zero count where the second strobe lands in resolve
		first_ops = random_ops();
		start_run(0);
		send_group(first_ops, 0);
		send_group(random_ops(), 0);
		wait_done();
		check_value("sum", lane_sum(first_ops), sum);
		repeat (3) @(negedge clk);
		finish_test("gaps, start while busy, zero count");

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0 && failed == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// run limit
	initial begin
		while (cycles <= cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: simulation ran past %0d cycles without finishing", cycle_limit);
		$display("=== FAIL ===");
		$finish;
	end

endmodule
